// ==== source/mult_macros.svh ====
// Multiply unit widths
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// operand width, also the width of the HI and LO words
`define MULT_WIDTH 32

// shift counter width
// top bit set means all 32 shifts are done
`define MULT_CNT_WIDTH 6

// full product, HI and LO side by side
`define MULT_PROD_WIDTH (2 * `MULT_WIDTH)

`endif

// ==== source/mult_data_pkg.sv ====
// Multiply data types
`default_nettype none

`include "mult_macros.svh"

package mult_data_pkg;

  // the two 32-bit halves of the product register
  typedef struct packed {
    logic [`MULT_WIDTH-1:0] hi; // add target, becomes HI
    logic [`MULT_WIDTH-1:0] lo; // starts as the multiplier, becomes LO
  } mult_halves_t;

  // product register, seen as one word for the shift
  // and as two halves for the add and the result split
  typedef union packed {
    logic [`MULT_PROD_WIDTH-1:0] whole;
    mult_halves_t                half;
  } mult_product_u;

endpackage

`default_nettype wire

// ==== source/mult_ctrl_pkg.sv ====
// Multiply control types
`default_nettype none

package mult_ctrl_pkg;

  // operation the datapath does this cycle
  typedef enum logic {
    STEP_ADD   = 1'b0, // add the selected source into hi
    STEP_SHIFT = 1'b1  // shift carry, hi and lo right by one
  } mult_step_e;

  // what goes into hi on an add step
  // on a shift step ADD_ZERO means hold, the product stays frozen
  typedef enum logic {
    ADD_MCAND = 1'b0, // product lsb was 1
    ADD_ZERO  = 1'b1  // product lsb was 0
  } mult_addend_e;

endpackage

`default_nettype wire

// ==== source/multu_operand_stage.sv ====
// Multiply operand stage
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_operand_stage
(
  input  logic                   m_clk,
  input  logic                   arst_n,
  input  logic                   do_mult,      // start strobe, sampled each edge
  input  logic                   busy,         // engine running
  input  logic [`MULT_WIDTH-1:0] multiplicand,
  input  logic [`MULT_WIDTH-1:0] multiplier,
  output logic                   load,         // one-cycle start to the engine
  output logic [`MULT_WIDTH-1:0] load_mcand,
  output logic [`MULT_WIDTH-1:0] load_mplier
);

  logic accept;

  // start is taken only when the engine is idle and no load is in flight
  // busy rises one cycle after load, so load covers that gap
  assign accept = do_mult && !busy && !load;

  always_ff @(posedge m_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      load <= 1'b0;
    end
    else
    begin
      load <= accept; // a held start gives one pulse
    end
  end

  // operand latches, only written on accept
  always_ff @(posedge m_clk)
  begin
    if (accept)
    begin
      load_mcand  <= multiplicand;
      load_mplier <= multiplier;
    end
  end

endmodule

`default_nettype wire

// ==== source/multu_control.sv ====
// Multiply shift-add control
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_control import mult_ctrl_pkg::*;
(
  input  logic         m_clk,
  input  logic         arst_n,
  input  logic         load,      // start of a new multiply
  input  logic         prod_lsb,  // lsb of the product lo half
  output mult_step_e   step,      // add or shift this cycle
  output mult_addend_e addend,    // multiplicand or zero on add steps
  output logic         busy,      // multiply in progress
  output logic         step_done  // one cycle, product is final
);

  mult_step_e                 op_q;          // which op comes next
  logic [`MULT_CNT_WIDTH-1:0] shift_cnt;     // shifts done so far
  logic [`MULT_CNT_WIDTH-1:0] shift_cnt_inc;
  logic                       cnt_top;       // 32 shifts reached
  logic                       cnt_top_q;     // delayed copy for the edge detect
  logic                       shifting;
  logic                       last_shift;

  assign shift_cnt_inc = shift_cnt + `MULT_CNT_WIDTH'(1);
  assign cnt_top       = shift_cnt[`MULT_CNT_WIDTH-1];
  assign shifting      = busy && (op_q == STEP_SHIFT);
  // the 32nd shift, count rolls into the top bit
  assign last_shift    = shifting && shift_cnt_inc[`MULT_CNT_WIDTH-1];

  always_ff @(posedge m_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      op_q      <= STEP_SHIFT;
      busy      <= 1'b0;
      shift_cnt <= '0;
      cnt_top_q <= 1'b0;
    end
    else
    begin
      cnt_top_q <= cnt_top;
      if (load)
      begin
        op_q      <= STEP_ADD; // always begin with an add
        busy      <= 1'b1;
        shift_cnt <= '0;
      end
      else if (busy)
      begin
        // alternate add, shift, add, shift ...
        op_q <= (op_q == STEP_ADD) ? STEP_SHIFT : STEP_ADD;
        if (shifting)
        begin
          shift_cnt <= shift_cnt_inc;
        end
        if (last_shift)
        begin
          busy <= 1'b0; // drops together with the top bit rising
        end
      end
    end
  end

  // step and source select
  always_comb
  begin
    if (busy)
    begin
      step = op_q;
      if (op_q == STEP_ADD)
        addend = mult_addend_e'(~prod_lsb); // lsb 1 adds the multiplicand
      else
        addend = ADD_MCAND; // plain shift
    end
    else
    begin
      // idle or finished, hold the product where it is
      step   = STEP_SHIFT;
      addend = ADD_ZERO;
    end
  end

  // rising edge of the counter top bit
  assign step_done = cnt_top && !cnt_top_q;

endmodule

`default_nettype wire

// ==== source/multu_datapath.sv ====
// Multiply shift-add datapath
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_datapath import mult_data_pkg::*, mult_ctrl_pkg::*;
(
  input  logic                   m_clk,
  input  logic                   arst_n,
  input  logic                   load,        // start, load the operands
  input  logic [`MULT_WIDTH-1:0] load_mcand,
  input  logic [`MULT_WIDTH-1:0] load_mplier,
  input  mult_step_e             step,
  input  mult_addend_e           addend,
  output logic                   prod_lsb,    // decides the next addend
  output mult_product_u          product
);

  logic [`MULT_WIDTH-1:0] mcand_q;  // multiplicand, held for the whole run
  logic [`MULT_WIDTH-1:0] add_val;  // multiplicand or zero
  logic [`MULT_WIDTH:0]   sum;      // 33 bits, carry out on top
  logic                   carry;    // add carry, waits for the next shift
  mult_product_u          prod_q;

  assign add_val = (addend == ADD_MCAND) ? mcand_q : '0;
  assign sum     = {1'b0, prod_q.half.hi} + {1'b0, add_val};

  always_ff @(posedge m_clk)
  begin
    if (load)
    begin
      mcand_q <= load_mcand;
    end
  end

  always_ff @(posedge m_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      prod_q <= '0;
      carry  <= 1'b0;
    end
    else if (load)
    begin
      prod_q.half.hi <= '0;          // accumulator starts empty
      prod_q.half.lo <= load_mplier; // multiplier bits shift out of lo
      carry          <= 1'b0;
    end
    else if (step == STEP_ADD)
    begin
      {carry, prod_q.half.hi} <= sum;
    end
    else if (addend == ADD_MCAND)
    begin
      // 65-bit right shift, the carry enters at the top of hi
      prod_q.whole <= {carry, prod_q.whole[`MULT_PROD_WIDTH-1:1]};
      carry        <= 1'b0;
    end
    // shift with zero source is the hold code, nothing changes
  end

  assign prod_lsb = prod_q.half.lo[0];
  assign product  = prod_q;

endmodule

`default_nettype wire

// ==== source/multu_result_stage.sv ====
// Multiply result stage
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_result_stage import mult_data_pkg::*;
(
  input  logic                   m_clk,
  input  logic                   arst_n,
  input  logic                   step_done, // product is final this cycle
  input  mult_product_u          product,
  output logic [`MULT_WIDTH-1:0] hi,        // architectural HI
  output logic [`MULT_WIDTH-1:0] lo,        // architectural LO
  output logic                   mult_done  // one cycle, hi and lo valid
);

  always_ff @(posedge m_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hi        <= '0;
      lo        <= '0;
      mult_done <= 1'b0;
    end
    else
    begin
      mult_done <= step_done; // step_done is a single pulse
      if (step_done)
      begin
        // split into the two words
        hi <= product.half.hi;
        lo <= product.half.lo;
      end
      // otherwise HI and LO keep the last result
    end
  end

endmodule

`default_nettype wire

// ==== source/multu_top.sv ====
// Unsigned multiply unit
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_top import mult_data_pkg::*, mult_ctrl_pkg::*;
(
  input  logic                   m_clk,
  input  logic                   arst_n,
  input  logic                   do_mult,
  input  logic [`MULT_WIDTH-1:0] multiplicand,
  input  logic [`MULT_WIDTH-1:0] multiplier,
  output logic [`MULT_WIDTH-1:0] hi,
  output logic [`MULT_WIDTH-1:0] lo,
  output logic                   mult_done
);

  logic                   load;
  logic [`MULT_WIDTH-1:0] load_mcand;
  logic [`MULT_WIDTH-1:0] load_mplier;
  logic                   busy;
  mult_step_e             step;
  mult_addend_e           addend;
  logic                   prod_lsb;
  mult_product_u          product;
  logic                   step_done;

  // start strobe and operand latch
  multu_operand_stage u_operand (
    .m_clk(m_clk), .arst_n(arst_n), .do_mult(do_mult), .busy(busy),
    .multiplicand(multiplicand), .multiplier(multiplier),
    .load(load), .load_mcand(load_mcand), .load_mplier(load_mplier)
  );

  // engine, control half
  multu_control u_control (
    .m_clk(m_clk), .arst_n(arst_n), .load(load), .prod_lsb(prod_lsb),
    .step(step), .addend(addend), .busy(busy), .step_done(step_done)
  );

  // engine, data half
  multu_datapath u_datapath (
    .m_clk(m_clk), .arst_n(arst_n), .load(load),
    .load_mcand(load_mcand), .load_mplier(load_mplier),
    .step(step), .addend(addend), .prod_lsb(prod_lsb), .product(product)
  );

  // HI and LO registers
  multu_result_stage u_result (
    .m_clk(m_clk), .arst_n(arst_n), .step_done(step_done), .product(product),
    .hi(hi), .lo(lo), .mult_done(mult_done)
  );

endmodule

`default_nettype wire

// ==== bench/multu_tb.sv ====
// Multiply unit testbench
`timescale 1ns/1ps
`default_nettype none

`include "mult_macros.svh"

module multu_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = 66;  // sampled start to mult_done high
  localparam int DONE_TIMEOUT = 100; // per multiply
  localparam int N_CORNER     = 12;
  localparam int N_RANDOM     = 200;
  localparam int N_BUSY       = 20;  // runs with ignored starts thrown in
  localparam int N_HELD       = 4;   // runs with a start held 5 cycles
  localparam int NUM_TESTS    = N_CORNER + N_RANDOM + N_BUSY + N_HELD;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 80 + RESET_CYCLES;
  localparam logic [31:0] SEED = 32'h2fa92c67;

  logic                   m_clk;
  logic                   arst_n;
  logic                   do_mult;
  logic [`MULT_WIDTH-1:0] multiplicand;
  logic [`MULT_WIDTH-1:0] multiplier;
  logic [`MULT_WIDTH-1:0] hi;
  logic [`MULT_WIDTH-1:0] lo;
  logic                   mult_done;

  integer                 seed;
  int                     cyc;            // rising edges so far
  int                     value_errors;
  int                     timing_errors;
  int                     done_pulses;    // seen by the monitor
  int                     expected_done;  // multiplies started by the bench
  bit                     done_q;
  logic [`MULT_WIDTH-1:0] last_hi;        // model's last HI that must hold between runs
  logic [`MULT_WIDTH-1:0] last_lo;
  logic [`MULT_WIDTH-1:0] corner_a [N_CORNER];
  logic [`MULT_WIDTH-1:0] corner_b [N_CORNER];

  multu_top DUT (
    .m_clk(m_clk), .arst_n(arst_n), .do_mult(do_mult),
    .multiplicand(multiplicand), .multiplier(multiplier),
    .hi(hi), .lo(lo), .mult_done(mult_done)
  );

  initial
  begin
    m_clk = 1'b0;
    forever #(CLK_PERIOD / 2) m_clk = ~m_clk;
  end

  always @(posedge m_clk)
    cyc <= cyc + 1;

  // counts done pulses and flags a pulse wider than one cycle
  always @(negedge m_clk)
  begin
    if (mult_done && !done_q)
      done_pulses++;
    if (mult_done && done_q)
    begin
      $display("mult_done stayed high for more than one cycle at edge %0d", cyc);
      timing_errors++;
    end
    done_q = mult_done;
  end

  // unsigned 64-bit reference product
  function automatic logic [`MULT_PROD_WIDTH-1:0] model_product(
    input logic [`MULT_WIDTH-1:0] a,
    input logic [`MULT_WIDTH-1:0] b
  );
    logic [`MULT_PROD_WIDTH-1:0] wide_a;
    logic [`MULT_PROD_WIDTH-1:0] wide_b;
    wide_a = {{`MULT_WIDTH{1'b0}}, a};
    wide_b = {{`MULT_WIDTH{1'b0}}, b};
    return wide_a * wide_b;
  endfunction

  // one multiply from start to result and a short idle gap after it
  task automatic run_multiply(
    input logic [`MULT_WIDTH-1:0] a,
    input logic [`MULT_WIDTH-1:0] b,
    input int                     hold_cycles, // edges that see do_mult high
    input bit                     noisy        // stray starts while busy
  );
    logic [`MULT_PROD_WIDTH-1:0] expected;
    logic [`MULT_WIDTH-1:0]      exp_hi;
    logic [`MULT_WIDTH-1:0]      exp_lo;
    int                          start_edge;
    int                          wait_cnt;
    int                          gap;
    bit                          seen;
    expected = model_product(a, b);
    exp_hi   = expected[`MULT_PROD_WIDTH-1:`MULT_WIDTH];
    exp_lo   = expected[`MULT_WIDTH-1:0];
    @(posedge m_clk);
    multiplicand <= a;
    multiplier   <= b;
    do_mult      <= 1'b1;
    @(negedge m_clk);
    start_edge = cyc + 1; // next edge samples the start
    wait_cnt   = 0;
    seen       = 1'b0;
    while (!seen && wait_cnt < DONE_TIMEOUT)
    begin
      @(posedge m_clk);
      wait_cnt++;
      if (wait_cnt < hold_cycles)
      begin
        // operands move on under the held start and must be ignored
        multiplicand <= $random(seed);
        multiplier   <= $random(seed);
      end
      else if (noisy && wait_cnt > 2 && wait_cnt < 60 && ($random(seed) & 7) == 0)
      begin
        do_mult      <= 1'b1; // lands while busy is high
        multiplicand <= $random(seed);
        multiplier   <= $random(seed);
      end
      else
        do_mult <= 1'b0;
      @(negedge m_clk);
      if (mult_done)
        seen = 1'b1;
      else
      begin
        // old result holds until the new one lands
        if (hi !== last_hi)
        begin
          $display("ERR hi: expected %h, got %h (hold)", last_hi, hi);
          value_errors++;
        end
        if (lo !== last_lo)
        begin
          $display("ERR lo: expected %h, got %h (hold)", last_lo, lo);
          value_errors++;
        end
      end
    end
    expected_done++;
    if (!seen)
    begin
      $display("no mult_done within %0d cycles of the start at edge %0d",
               DONE_TIMEOUT, start_edge);
      timing_errors++;
    end
    else
    begin
      if (cyc - start_edge != LATENCY)
      begin
        $display("mult_done came %0d cycles after the start, expected %0d",
                 cyc - start_edge, LATENCY);
        timing_errors++;
      end
      if (hi !== exp_hi)
      begin
        $display("ERR hi: expected %h, got %h (a %h, b %h)", exp_hi, hi, a, b);
        value_errors++;
      end
      if (lo !== exp_lo)
      begin
        $display("ERR lo: expected %h, got %h (a %h, b %h)", exp_lo, lo, a, b);
        value_errors++;
      end
    end
    last_hi = exp_hi;
    last_lo = exp_lo;
    gap = $random(seed) & 3;
    repeat (gap + 1)
    begin
      @(negedge m_clk);
      if (hi !== last_hi || lo !== last_lo)
      begin
        $display("ERR hi/lo: expected %h_%h, got %h_%h (idle)", last_hi, last_lo, hi, lo);
        value_errors++;
      end
    end
  endtask

  // main sequence
  initial
  begin
    int                     i;
    logic [`MULT_WIDTH-1:0] a_op;
    logic [`MULT_WIDTH-1:0] b_op;
    do_mult      <= 1'b0;
    multiplicand <= '0;
    multiplier   <= '0;
    arst_n       <= 1'b0;
    seed          = SEED;
    value_errors  = 0;
    timing_errors = 0;
    expected_done = 0;
    last_hi       = '0;
    last_lo       = '0;

    // corner operands for the zero paths, carries into hi and powers of two
    corner_a[0]  = '0;
    corner_b[0]  = $random(seed);
    corner_a[1]  = $random(seed);
    corner_b[1]  = '0;
    corner_a[2]  = '0;
    corner_b[2]  = '0;
    corner_a[3]  = '1;
    corner_b[3]  = '1; // FFFFFFFE_00000001
    corner_a[4]  = 32'h1;
    corner_b[4]  = $random(seed);
    corner_a[5]  = $random(seed);
    corner_b[5]  = 32'h1;
    corner_a[6]  = 32'h80000000;
    corner_b[6]  = 32'h80000000;
    corner_a[7]  = 32'h1 << ($random(seed) & 31);
    corner_b[7]  = 32'h1 << ($random(seed) & 31);
    corner_a[8]  = 32'h80000000;
    corner_b[8]  = '1;
    corner_a[9]  = '1;
    corner_b[9]  = 32'h1;
    corner_a[10] = 32'h00010000;
    corner_b[10] = 32'h00010000; // carries into hi bit 0
    corner_a[11] = '1;
    corner_b[11] = 32'h2;

    repeat (RESET_CYCLES) @(posedge m_clk);
    arst_n <= 1'b1;
    @(negedge m_clk);
    if (mult_done !== 1'b0)
    begin
      $display("ERR mult_done: expected %h, got %h (reset)", 1'b0, mult_done);
      value_errors++;
    end
    if (hi !== '0 || lo !== '0)
    begin
      $display("ERR hi/lo: expected %h_%h, got %h_%h (reset)", last_hi, last_lo, hi, lo);
      value_errors++;
    end

    for (i = 0; i < N_CORNER; i++)
      run_multiply(corner_a[i], corner_b[i], 1, 1'b0);
    for (i = 0; i < N_RANDOM; i++)
    begin
      a_op = $random(seed);
      b_op = $random(seed);
      run_multiply(a_op, b_op, 1, 1'b0);
    end
    for (i = 0; i < N_BUSY; i++)
    begin
      a_op = $random(seed);
      b_op = $random(seed);
      run_multiply(a_op, b_op, 1, 1'b1);
    end
    for (i = 0; i < N_HELD; i++)
    begin
      a_op = $random(seed);
      b_op = $random(seed);
      run_multiply(a_op, b_op, 5, 1'b0);
    end

    repeat (5) @(posedge m_clk); // room for a stray late pulse
    if (done_pulses != expected_done)
    begin
      $display("saw %0d mult_done pulses for %0d multiplies", done_pulses, expected_done);
      timing_errors++;
    end

    $display("errors: %0d value, %0d timing", value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog sized from the number of runs
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== multu.f ====
+incdir+source
source/mult_data_pkg.sv
source/mult_ctrl_pkg.sv
source/multu_operand_stage.sv
source/multu_control.sv
source/multu_datapath.sv
source/multu_result_stage.sv
source/multu_top.sv
bench/multu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module multu_tb -f multu.f \
  --Mdir obj_dir -o multu_sim

out=$(./obj_dir/multu_sim)
echo "$out"

if echo "$out" | grep -q -x "Simulation passed"; then
  exit 0
else
  exit 1
fi
